/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_radio_ctrl_core
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/ctrl_regs.sv */
/*
 * Control register bank
 * Clock, SERDES, ADC and PHY control lines plus the LED source mux
 */
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs #(
   parameter radio_types_pkg::set_addr_t BASE = radio_regs_pkg::SR_MISC
) (
   input  wire                        dsp_clk,
   input  wire                        por_rst,
   input  wire                        set_stb_i,
   input  wire radio_types_pkg::set_addr_t set_addr_i,
   input  wire radio_types_pkg::set_data_t set_data_i,
   input  wire                        run_rx_i,
   input  wire                        run_tx_i,
   input  wire                        clk_status_i,
   input  wire                        serdes_link_up_i,
   input  wire                        good_sync_i,
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o,
   output radio_types_pkg::ctrl_byte_t leds_o
);

   radio_types_pkg::ctrl_byte_t clock_outs, serdes_outs, adc_outs;
   radio_types_pkg::ctrl_byte_t led_sw, led_src, led_hw;
   logic phy_reset;

   //////////////////////////////
   // Register bank
   setting_reg #(.payload_t(radio_types_pkg::ctrl_byte_t), .MY_ADDR(BASE + radio_regs_pkg::MISC_CLK))
   u_sr_clk (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
             .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(clock_outs), .changed_o());

   setting_reg #(.payload_t(radio_types_pkg::ctrl_byte_t), .MY_ADDR(BASE + radio_regs_pkg::MISC_SER))
   u_sr_ser (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
             .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(serdes_outs), .changed_o());

   setting_reg #(.payload_t(radio_types_pkg::ctrl_byte_t), .MY_ADDR(BASE + radio_regs_pkg::MISC_ADC))
   u_sr_adc (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
             .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(adc_outs), .changed_o());

   setting_reg #(.payload_t(radio_types_pkg::ctrl_byte_t),
                 .MY_ADDR(BASE + radio_regs_pkg::MISC_LED_SW))
   u_sr_led_sw (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
                .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(led_sw), .changed_o());

   setting_reg #(.payload_t(logic), .MY_ADDR(BASE + radio_regs_pkg::MISC_PHY))
   u_sr_phy (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
             .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(phy_reset), .changed_o());

   setting_reg #(.payload_t(radio_types_pkg::ctrl_byte_t),
                 .MY_ADDR(BASE + radio_regs_pkg::MISC_LED_SRC),
                 .AT_RESET(radio_regs_pkg::LED_SRC_AT_RESET))
   u_sr_led_src (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
                 .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(led_src),
                 .changed_o());

   // Control line slices
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_outs[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_outs[3:0];
   assign phy_reset_n_o = ~phy_reset;

   //////////////////////////////
   // LEDs, per bit 1 = hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

/* logic/radio_ctrl_core.sv */
/*
 * Radio control core
 * Control registers, VITA timer and readback on dsp_clk
 */
`timescale 1ns/1ns
`default_nettype none

module radio_ctrl_core #(
   parameter radio_types_pkg::set_addr_t MISC_BASE = radio_regs_pkg::SR_MISC,
   parameter radio_types_pkg::set_addr_t TIME_BASE = radio_regs_pkg::SR_TIME64
) (
   input  wire                        dsp_clk,
   input  wire                        por_rst,
   // Settings bus
   input  wire                        set_stb_i,
   input  wire radio_types_pkg::set_addr_t set_addr_i,
   input  wire radio_types_pkg::set_data_t set_data_i,
   // Board inputs
   input  wire                        pps_i,
   input  wire                        run_rx_i,
   input  wire                        run_tx_i,
   input  wire                        clk_status_i,
   input  wire                        serdes_link_up_i,
   input  wire                        button_i,
   // Control lines
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o,
   output radio_types_pkg::ctrl_byte_t leds_o,
   // Readback
   input  wire radio_types_pkg::rb_addr_t rb_addr_i,
   output radio_types_pkg::rb_word_t  rb_data_o
);

   radio_types_pkg::vita_time_t vita_time, vita_time_pps;
   logic good_sync;

   ctrl_regs #(.BASE(MISC_BASE)) u_ctrl_regs (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .good_sync_i(good_sync),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o)
   );

   vita_timer #(.BASE(TIME_BASE)) u_vita_timer (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .good_sync_o(good_sync)
   );

   readback_mux #(.COMPAT(radio_regs_pkg::COMPAT_NUM)) u_readback_mux (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .rb_addr_i(rb_addr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .button_i(button_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .rb_data_o(rb_data_o)
   );

endmodule

`default_nettype wire

/* logic/radio_regs_pkg.sv */
/*
 * Radio register map
 * Settings addresses, readback word indices and reset values
 */
`default_nettype none

package radio_regs_pkg;

   //////////////////////////////
   // Misc control block, 7 regs
   localparam radio_types_pkg::set_addr_t SR_MISC      = 8'd0;
   localparam radio_types_pkg::set_addr_t MISC_CLK     = 8'd0;
   localparam radio_types_pkg::set_addr_t MISC_SER     = 8'd1;
   localparam radio_types_pkg::set_addr_t MISC_ADC     = 8'd2;
   localparam radio_types_pkg::set_addr_t MISC_LED_SW  = 8'd3;
   localparam radio_types_pkg::set_addr_t MISC_PHY     = 8'd4;
   localparam radio_types_pkg::set_addr_t MISC_LED_SRC = 8'd6;

   // Time block, offsets from SR_TIME64
   localparam radio_types_pkg::set_addr_t SR_TIME64 = 8'd10;
   localparam radio_types_pkg::set_addr_t TIME_HI   = 8'd0;
   localparam radio_types_pkg::set_addr_t TIME_LO   = 8'd1;
   localparam radio_types_pkg::set_addr_t TIME_CTRL = 8'd2;

   //////////////////////////////
   // Readback word indices
   localparam radio_types_pkg::rb_addr_t RB_TIME_HI = 4'd10;
   localparam radio_types_pkg::rb_addr_t RB_TIME_LO = 4'd11;
   localparam radio_types_pkg::rb_addr_t RB_COMPAT  = 4'd12;
   localparam radio_types_pkg::rb_addr_t RB_STATUS  = 4'd13;
   localparam radio_types_pkg::rb_addr_t RB_PPS_HI  = 4'd14;
   localparam radio_types_pkg::rb_addr_t RB_PPS_LO  = 4'd15;

   // Bump major when the register map changes
   localparam radio_types_pkg::rb_word_t COMPAT_NUM = {16'd9, 16'd0};

   // 1 = hardware drives the LED, 0 = software
   localparam radio_types_pkg::ctrl_byte_t LED_SRC_AT_RESET = 8'b0001_1110;

endpackage

`default_nettype wire

/* logic/radio_types_pkg.sv */
/*
 * Radio control types
 * Widths of the settings bus, VITA time and readback words
 */
`default_nettype none

package radio_types_pkg;

   //////////////////////////////
   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;

   // One control register
   typedef logic [7:0] ctrl_byte_t;

   //////////////////////////////
   // Time and readback
   localparam int TIME_W = 64;
   localparam int RB_ADDR_W = 4;

   typedef logic [TIME_W-1:0]    vita_time_t;
   typedef logic [RB_ADDR_W-1:0] rb_addr_t;
   typedef logic [31:0]          rb_word_t;

endpackage

`default_nettype wire

/* logic/readback_mux.sv */
/*
 * Readback mux
 * Registered selection of one of 16 status words
 */
`timescale 1ns/1ns
`default_nettype none

module readback_mux #(
   parameter radio_types_pkg::rb_word_t COMPAT = radio_regs_pkg::COMPAT_NUM
) (
   input  wire                         dsp_clk,
   input  wire                         por_rst,
   input  wire radio_types_pkg::rb_addr_t   rb_addr_i,
   input  wire radio_types_pkg::vita_time_t vita_time_i,
   input  wire radio_types_pkg::vita_time_t vita_time_pps_i,
   input  wire                         button_i,
   input  wire                         clk_status_i,
   input  wire                         serdes_link_up_i,
   output radio_types_pkg::rb_word_t   rb_data_o
);

   radio_types_pkg::rb_word_t status_word;
   radio_types_pkg::rb_word_t sel_word;

   // Board status bits
   assign status_word = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_comb begin
      case (rb_addr_i)
         radio_regs_pkg::RB_TIME_HI: sel_word = vita_time_i[63:32];
         radio_regs_pkg::RB_TIME_LO: sel_word = vita_time_i[31:0];
         radio_regs_pkg::RB_COMPAT:  sel_word = COMPAT;
         radio_regs_pkg::RB_STATUS:  sel_word = status_word;
         radio_regs_pkg::RB_PPS_HI:  sel_word = vita_time_pps_i[63:32];
         radio_regs_pkg::RB_PPS_LO:  sel_word = vita_time_pps_i[31:0];
         // Words 0 to 9 have no source here
         default:                    sel_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= sel_word;
      end
   end

   a_rb_addr_known : assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      !$isunknown(rb_addr_i)
   );

endmodule

`default_nettype wire

/* logic/setting_reg.sv */
/*
 * Settings register
 * Loads the low bits of the settings data on a matching strobe
 */
`timescale 1ns/1ns
`default_nettype none

module setting_reg #(
   parameter type payload_t = logic [7:0],
   parameter radio_types_pkg::set_addr_t MY_ADDR = 8'd0,
   parameter payload_t AT_RESET = '0
) (
   input  wire                        dsp_clk,
   input  wire                        por_rst,
   input  wire                        set_stb_i,
   input  wire radio_types_pkg::set_addr_t set_addr_i,
   input  wire radio_types_pkg::set_data_t set_data_i,
   output payload_t                   value_o,
   output logic                       changed_o
);

   localparam int PW = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         value_o   <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            value_o <= payload_t'(set_data_i[PW-1:0]);
         end
      end
   end

   // Bus master must hold a valid address with every strobe
   a_addr_known : assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      set_stb_i |-> !$isunknown(set_addr_i)
   );

endmodule

`default_nettype wire

/* logic/vita_timer.sv */
/*
 * VITA time counter
 * 64-bit count, immediate or PPS-armed load, PPS time latch
 */
`timescale 1ns/1ns
`default_nettype none

module vita_timer #(
   parameter radio_types_pkg::set_addr_t BASE = radio_regs_pkg::SR_TIME64
) (
   input  wire                        dsp_clk,
   input  wire                        por_rst,
   input  wire                        set_stb_i,
   input  wire radio_types_pkg::set_addr_t set_addr_i,
   input  wire radio_types_pkg::set_data_t set_data_i,
   input  wire                        pps_i,
   output radio_types_pkg::vita_time_t vita_time_o,
   output radio_types_pkg::vita_time_t vita_time_pps_o,
   output logic                       good_sync_o
);

   radio_types_pkg::set_data_t  time_hi, time_lo;
   radio_types_pkg::vita_time_t pending, next_time;
   logic       ctrl_arm;
   logic       commit;
   logic       load_now;
   logic       armed;
   logic [1:0] pps_sync;
   logic       pps_dly;
   logic       pps_edge;

   //////////////////////////////
   // Pending time and commit
   setting_reg #(.payload_t(radio_types_pkg::set_data_t), .MY_ADDR(BASE + radio_regs_pkg::TIME_HI))
   u_sr_time_hi (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
                 .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(time_hi),
                 .changed_o());

   setting_reg #(.payload_t(radio_types_pkg::set_data_t), .MY_ADDR(BASE + radio_regs_pkg::TIME_LO))
   u_sr_time_lo (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
                 .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(time_lo),
                 .changed_o());

   // Bit 0 picks armed (1) or immediate (0)
   setting_reg #(.payload_t(logic), .MY_ADDR(BASE + radio_regs_pkg::TIME_CTRL))
   u_sr_time_ctrl (.dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
                   .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(ctrl_arm),
                   .changed_o(commit));

   assign pending  = {time_hi, time_lo};
   assign load_now = commit & ~ctrl_arm;
   assign pps_edge = pps_sync[1] & ~pps_dly;

   // Value the counter takes on this edge, also what the PPS latch sees
   always_comb begin
      if (load_now || (pps_edge && armed)) begin
         next_time = pending;
      end else begin
         next_time = vita_time_o + 64'd1;
      end
   end

   //////////////////////////////
   // Counter, PPS edge, arm flag
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync        <= 2'b00;
         pps_dly         <= 1'b0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         armed           <= 1'b0;
         good_sync_o     <= 1'b0;
      end else begin
         pps_sync    <= {pps_sync[0], pps_i};
         pps_dly     <= pps_sync[1];
         vita_time_o <= next_time;
         if (pps_edge) begin
            vita_time_pps_o <= next_time;
         end
         if (commit && ctrl_arm) begin
            armed <= 1'b1;
         end else if (pps_edge) begin
            armed <= 1'b0;
         end
         // Sticky until reset
         if (pps_edge && armed) begin
            good_sync_o <= 1'b1;
         end
      end
   end

   // Software must not issue an immediate load while a PPS load waits
   a_no_load_while_armed : assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      !(armed && load_now)
   );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
/*
 * Testbench clock and reset
 * 10 ns dsp_clk, por_rst high for the first 10 rising edges
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 10
) (
   output logic dsp_clk,
   output logic por_rst
);

   initial begin
      dsp_clk = 1'b0;
      forever #(PERIOD_NS / 2) dsp_clk = ~dsp_clk;
   end

   // Release on a falling edge, like every other input
   initial begin
      por_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;
   end

endmodule

`default_nettype wire

/* tb/tb_radio_ctrl_core.sv */
/*
 * Radio control core testbench
 * Register writes, LED mux, readback and VITA time loads against a model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_radio_ctrl_core;

   localparam radio_types_pkg::set_addr_t MISC_BASE = radio_regs_pkg::SR_MISC;
   localparam radio_types_pkg::set_addr_t TIME_BASE = radio_regs_pkg::SR_TIME64;

   localparam radio_types_pkg::set_addr_t ADDR_CLK       = MISC_BASE + radio_regs_pkg::MISC_CLK;
   localparam radio_types_pkg::set_addr_t ADDR_SER       = MISC_BASE + radio_regs_pkg::MISC_SER;
   localparam radio_types_pkg::set_addr_t ADDR_ADC       = MISC_BASE + radio_regs_pkg::MISC_ADC;
   localparam radio_types_pkg::set_addr_t ADDR_LED_SW    = MISC_BASE + radio_regs_pkg::MISC_LED_SW;
   localparam radio_types_pkg::set_addr_t ADDR_PHY       = MISC_BASE + radio_regs_pkg::MISC_PHY;
   localparam radio_types_pkg::set_addr_t ADDR_LED_SRC   = MISC_BASE + radio_regs_pkg::MISC_LED_SRC;
   localparam radio_types_pkg::set_addr_t ADDR_TIME_HI   = TIME_BASE + radio_regs_pkg::TIME_HI;
   localparam radio_types_pkg::set_addr_t ADDR_TIME_LO   = TIME_BASE + radio_regs_pkg::TIME_LO;
   localparam radio_types_pkg::set_addr_t ADDR_TIME_CTRL = TIME_BASE + radio_regs_pkg::TIME_CTRL;

   //////////////////////////////
   // Test lengths and timeout
   localparam int N_CTRL_WRITES  = 40;
   localparam int N_BAD_WRITES   = 20;
   localparam int N_LED_ROUNDS   = 30;
   localparam int N_RB_READS     = 30;
   localparam int N_TIME_LOADS   = 6;
   localparam int PPS_WAIT_LIMIT = 10;
   // Rough cycles per phase plus reset and the PPS phase
   localparam int TEST_CYCLES = 2 * N_CTRL_WRITES + 2 * N_BAD_WRITES + 4 * N_LED_ROUNDS
                              + 2 * N_RB_READS + 13 * N_TIME_LOADS + 60;
   localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

   logic dsp_clk;
   logic por_rst;

   // DUT inputs
   logic                          set_stb;
   radio_types_pkg::set_addr_t    set_addr;
   radio_types_pkg::set_data_t    set_data;
   logic                          pps;
   logic                          run_rx;
   logic                          run_tx;
   logic                          clk_status;
   logic                          serdes_link_up;
   logic                          button;
   radio_types_pkg::rb_addr_t     rb_addr;

   // DUT outputs
   logic                          clock_ready;
   logic [1:0]                    clk_en;
   logic [1:0]                    clk_sel;
   logic                          ser_enable;
   logic                          ser_prbsen;
   logic                          ser_loopen;
   logic                          ser_rx_en;
   logic                          adc_oe_a;
   logic                          adc_on_a;
   logic                          adc_oe_b;
   logic                          adc_on_b;
   logic                          phy_reset_n;
   radio_types_pkg::ctrl_byte_t   leds;
   radio_types_pkg::rb_word_t     rb_data;

   // Register model
   radio_types_pkg::ctrl_byte_t   model_clk, model_ser, model_adc;
   radio_types_pkg::ctrl_byte_t   model_led_sw, model_led_src;
   logic                          model_phy;
   logic                          model_good_sync;
   logic                          ctrl_check_en;

   int                            error_count;
   int                            check_count;
   int                            cycle_count;
   logic [21:0]                   exp_lines;

   // Stimulus scratch
   logic [31:0]                   rnd;
   radio_types_pkg::set_addr_t    addr;
   radio_types_pkg::rb_addr_t     addr4;
   radio_types_pkg::rb_word_t     word;
   radio_types_pkg::vita_time_t   t_load;
   string                         rb_name;
   int                            n_req;
   int                            wait_n;

   tb_clkgen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clkgen (
      .dsp_clk(dsp_clk),
      .por_rst(por_rst)
   );

   radio_ctrl_core #(.MISC_BASE(MISC_BASE), .TIME_BASE(TIME_BASE)) u_radio_ctrl_core (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps), .run_rx_i(run_rx), .run_tx_i(run_tx), .clk_status_i(clk_status),
      .serdes_link_up_i(serdes_link_up), .button_i(button),
      .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen),
      .ser_loopen_o(ser_loopen), .ser_rx_en_o(ser_rx_en),
      .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds),
      .rb_addr_i(rb_addr), .rb_data_o(rb_data)
   );

   //////////////////////////////
   // Reference model
   // Packed as clk[4:0] ser[3:0] adc[3:0] phy_reset_n leds[7:0]
   function automatic logic [21:0] expected_ctrl(
      input radio_types_pkg::ctrl_byte_t clk_r,
      input radio_types_pkg::ctrl_byte_t ser_r,
      input radio_types_pkg::ctrl_byte_t adc_r,
      input radio_types_pkg::ctrl_byte_t led_sw_r,
      input radio_types_pkg::ctrl_byte_t led_src_r,
      input logic phy_r,
      input logic rx, input logic tx, input logic clk_ok,
      input logic link_up, input logic gsync
   );
      radio_types_pkg::ctrl_byte_t hw;
      radio_types_pkg::ctrl_byte_t led_out;
      hw    = '0;
      hw[4] = tx;
      hw[3] = rx;
      hw[2] = clk_ok;
      hw[1] = link_up & gsync;
      for (int b = 0; b < 8; b++) begin
         led_out[b] = led_src_r[b] ? hw[b] : led_sw_r[b];
      end
      return {clk_r[4:0], ser_r[3:0], adc_r[3:0], ~phy_r, led_out};
   endfunction

   function automatic radio_types_pkg::rb_word_t expected_readback(
      input radio_types_pkg::rb_addr_t   idx,
      input radio_types_pkg::vita_time_t time_now,
      input radio_types_pkg::vita_time_t pps_time,
      input logic btn, input logic clk_ok, input logic link_up
   );
      radio_types_pkg::rb_word_t w;
      w = '0;
      case (idx)
         radio_regs_pkg::RB_TIME_HI: w = time_now[63:32];
         radio_regs_pkg::RB_TIME_LO: w = time_now[31:0];
         radio_regs_pkg::RB_COMPAT:  w = {16'd9, 16'd0};
         radio_regs_pkg::RB_STATUS: begin
            w[13] = btn;
            w[11] = clk_ok;
            w[10] = link_up;
         end
         radio_regs_pkg::RB_PPS_HI:  w = pps_time[63:32];
         radio_regs_pkg::RB_PPS_LO:  w = pps_time[31:0];
         default:                    w = '0;
      endcase
      return w;
   endfunction

   function automatic logic [21:0] ctrl_lines_now();
      return {clock_ready, clk_en, clk_sel, ser_enable, ser_prbsen, ser_loopen, ser_rx_en,
              adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_reset_n, leds};
   endfunction

   function automatic logic is_mapped(input radio_types_pkg::set_addr_t a);
      return a inside {ADDR_CLK, ADDR_SER, ADDR_ADC, ADDR_LED_SW, ADDR_PHY, ADDR_LED_SRC,
                       ADDR_TIME_HI, ADDR_TIME_LO, ADDR_TIME_CTRL};
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      end
   endtask

   // Register contents follow the settings bus
   always @(posedge dsp_clk) begin
      if (por_rst) begin
         model_clk     <= '0;
         model_ser     <= '0;
         model_adc     <= '0;
         model_led_sw  <= '0;
         model_led_src <= radio_regs_pkg::LED_SRC_AT_RESET;
         model_phy     <= 1'b0;
      end else if (set_stb) begin
         case (set_addr)
            ADDR_CLK:     model_clk     <= set_data[7:0];
            ADDR_SER:     model_ser     <= set_data[7:0];
            ADDR_ADC:     model_adc     <= set_data[7:0];
            ADDR_LED_SW:  model_led_sw  <= set_data[7:0];
            ADDR_PHY:     model_phy     <= set_data[0];
            ADDR_LED_SRC: model_led_src <= set_data[7:0];
            default: ;
         endcase
      end
   end

   // Control lines compared every cycle against their pre-edge values
   always @(posedge dsp_clk) begin
      if (!por_rst && ctrl_check_en) begin
         exp_lines = expected_ctrl(model_clk, model_ser, model_adc, model_led_sw,
                                   model_led_src, model_phy, run_rx, run_tx, clk_status,
                                   serdes_link_up, model_good_sync);
         check_value("clk_lines", 64'(exp_lines[21:17]), 64'(ctrl_lines_now() >> 17));
         check_value("ser_lines", 64'(exp_lines[16:13]), 64'(ctrl_lines_now() >> 13 & 22'hf));
         check_value("adc_lines", 64'(exp_lines[12:9]), 64'(ctrl_lines_now() >> 9 & 22'hf));
         check_value("phy_reset_n", 64'(exp_lines[8]), 64'(phy_reset_n));
         check_value("leds", 64'(exp_lines[7:0]), 64'(leds));
      end
   end

   always @(posedge dsp_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, stimulus did not finish", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus helpers
   task automatic next_cycle();
      @(negedge dsp_clk);
   endtask

   task automatic write_setting(input radio_types_pkg::set_addr_t a,
                                input radio_types_pkg::set_data_t d);
      set_stb  = 1'b1;
      set_addr = a;
      set_data = d;
      next_cycle();
      set_stb  = 1'b0;
   endtask

   task automatic read_word(input radio_types_pkg::rb_addr_t a,
                            output radio_types_pkg::rb_word_t w);
      rb_addr = a;
      next_cycle();
      w = rb_data;
   endtask

   task automatic randomize_board_inputs();
      logic [31:0] bits;
      bits           = $urandom();
      run_rx         = bits[0];
      run_tx         = bits[1];
      clk_status     = bits[2];
      serdes_link_up = bits[3];
      button         = bits[4];
   endtask

   initial begin
      void'($urandom(1));
      error_count     = 0;
      check_count     = 0;
      cycle_count     = 0;
      set_stb         = 1'b0;
      set_addr        = '0;
      set_data        = '0;
      pps             = 1'b0;
      rb_addr         = radio_regs_pkg::RB_COMPAT;
      ctrl_check_en   = 1'b1;
      model_good_sync = 1'b0;
      randomize_board_inputs();
      wait (por_rst == 1'b0);

      // Readback register still holds its reset value here
      check_value("reset_rb_data", 64'h0, 64'(rb_data));
      next_cycle();

      // Reset state
      check_value("reset_ctrl_lines",
                  64'(expected_ctrl(8'h00, 8'h00, 8'h00, 8'h00,
                                    radio_regs_pkg::LED_SRC_AT_RESET, 1'b0, run_rx, run_tx,
                                    clk_status, serdes_link_up, 1'b0)),
                  64'(ctrl_lines_now()));

      // Mapped control writes
      for (int i = 0; i < N_CTRL_WRITES; i++) begin
         rnd = $urandom();
         case (rnd[1:0])
            2'd0:    addr = ADDR_CLK;
            2'd1:    addr = ADDR_SER;
            2'd2:    addr = ADDR_ADC;
            default: addr = ADDR_PHY;
         endcase
         write_setting(addr, $urandom());
      end

      // Unmapped writes must leave everything alone
      for (int i = 0; i < N_BAD_WRITES; i++) begin
         rnd  = $urandom();
         addr = rnd[7:0];
         while (is_mapped(addr)) begin
            rnd  = $urandom();
            addr = rnd[7:0];
         end
         write_setting(addr, $urandom());
      end
      next_cycle();

      // LED source mux
      for (int i = 0; i < N_LED_ROUNDS; i++) begin
         randomize_board_inputs();
         write_setting(ADDR_LED_SW, $urandom());
         write_setting(ADDR_LED_SRC, $urandom());
         next_cycle();
         next_cycle();
      end

      // Compat, status and unused readback words
      for (int i = 0; i < N_RB_READS; i++) begin
         rnd = $urandom();
         case (rnd[1:0])
            2'd0: begin
               addr4   = radio_regs_pkg::RB_COMPAT;
               rb_name = "rb_compat";
            end
            2'd1: begin
               randomize_board_inputs();
               addr4   = radio_regs_pkg::RB_STATUS;
               rb_name = "rb_status";
            end
            default: begin
               addr4   = 4'(rnd[15:8] % 10);
               rb_name = "rb_zero";
            end
         endcase
         read_word(addr4, word);
         check_value(rb_name, 64'(expected_readback(addr4, '0, '0, button, clk_status,
                                                    serdes_link_up)), 64'(word));
      end

      ////////////////////////////////
      // Immediate time load
      for (int i = 0; i < N_TIME_LOADS; i++) begin
         t_load = {$urandom(), $urandom()};
         write_setting(ADDR_TIME_HI, t_load[63:32]);
         write_setting(ADDR_TIME_LO, t_load[31:0]);
         rnd = $urandom();
         write_setting(ADDR_TIME_CTRL, {rnd[31:1], 1'b0});
         // Now one cycle past the commit strobe
         n_req  = 1;
         rnd    = $urandom();
         wait_n = int'(rnd[2:0]) + 1;
         repeat (wait_n) next_cycle();
         n_req += wait_n;
         // Time is T at commit+2 and readback shows the count before its edge
         read_word(radio_regs_pkg::RB_TIME_LO, word);
         check_value("time_lo", 64'(expected_readback(radio_regs_pkg::RB_TIME_LO,
                                                      t_load + 64'(n_req - 2), '0, button,
                                                      clk_status, serdes_link_up)),
                     64'(word));
         n_req++;
         read_word(radio_regs_pkg::RB_TIME_HI, word);
         check_value("time_hi", 64'(expected_readback(radio_regs_pkg::RB_TIME_HI,
                                                      t_load + 64'(n_req - 2), '0, button,
                                                      clk_status, serdes_link_up)),
                     64'(word));
      end

      ////////////////////////////////
      // Armed load on PPS
      serdes_link_up = 1'b1;
      rnd = $urandom();
      write_setting(ADDR_LED_SRC, {rnd[31:2], 1'b1, rnd[0]});
      t_load = {$urandom(), $urandom()};
      write_setting(ADDR_TIME_HI, t_load[63:32]);
      write_setting(ADDR_TIME_LO, t_load[31:0]);
      rnd = $urandom();
      write_setting(ADDR_TIME_CTRL, {rnd[31:1], 1'b1});
      ctrl_check_en = 1'b0;
      pps    = 1'b1;
      wait_n = 0;
      while (leds[1] !== 1'b1 && wait_n < PPS_WAIT_LIMIT) begin
         next_cycle();
         wait_n++;
      end
      check_value("pps_good_sync_led", 64'h1, 64'(leds[1]));
      pps             = 1'b0;
      model_good_sync = 1'b1;
      ctrl_check_en   = 1'b1;
      read_word(radio_regs_pkg::RB_PPS_HI, word);
      check_value("pps_hi", 64'(expected_readback(radio_regs_pkg::RB_PPS_HI, '0, t_load,
                                                  button, clk_status, serdes_link_up)),
                  64'(word));
      read_word(radio_regs_pkg::RB_PPS_LO, word);
      check_value("pps_lo", 64'(expected_readback(radio_regs_pkg::RB_PPS_LO, '0, t_load,
                                                  button, clk_status, serdes_link_up)),
                  64'(word));
      // LED bit 1 also needs the link
      serdes_link_up = 1'b0;
      next_cycle();
      next_cycle();
      serdes_link_up = 1'b1;
      next_cycle();
      next_cycle();

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
logic/radio_types_pkg.sv
logic/radio_regs_pkg.sv
logic/setting_reg.sv
logic/ctrl_regs.sv
logic/vita_timer.sv
logic/readback_mux.sv
logic/radio_ctrl_core.sv
tb/tb_clkgen.sv
tb/tb_radio_ctrl_core.sv
